// File: source/trigger_timing_pkg.sv
package trigger_timing_pkg;

	//////////////////////////////
	// clock and frame relation

	// clk80 and clk400 share their rising edges
	localparam int clk_ratio = 5; // clk400 cycles per clk80 cycle

	// one 40 MHz bunch frame spans two clk80 cycles
	localparam int frame_len = 2 * clk_ratio; // clk400 cycles per frame

	//////////////////////////////
	// input filter

	// the filter needs a window this long before it can call an edge real
	localparam int denoise_delay = 4; // first high sample to filtered level

	//////////////////////////////
	// position inside a frame

	// counts 0 to frame_len - 1 from the frame start
	typedef logic [$clog2(frame_len)-1:0] frame_pos_t;

endpackage

// File: source/trigger_event_pkg.sv
package trigger_event_pkg;

	import trigger_timing_pkg::*;

	//////////////////////////////
	// field types

	typedef logic [7:0] source_t; // channel index carried in the output word

	typedef logic [15:0] event_num_t; // running event number

	//////////////////////////////
	// channel to selector

	// hit is high for one clk80 cycle right after a clk80 edge with sync
	typedef struct packed
	{
		logic hit;
		frame_pos_t pos; // clk400 cycle of the frame where the trigger started
	} chan_trigger_t;

	//////////////////////////////
	// output of the front end

	typedef struct packed
	{
		logic valid; // single clk80 strobe
		source_t source; // winning channel
		frame_pos_t pos;
		event_num_t number; // starts at zero after reset
	} trigger_word_t;

endpackage

// File: source/frame_sync_gen.sv
`timescale 1ns/100ps

module frame_sync_gen
	import trigger_timing_pkg::*;
(
	input  logic clk80,
	input  logic reset,
	output logic sync
);

	localparam int frame_clk80 = frame_len / clk_ratio; // clk80 cycles per frame

	logic phase;

	// alternate clk80 cycles are frame boundaries
	always_ff @(posedge clk80 or posedge reset)
	begin
		if (reset)
			phase <= 1'b0;
		else
			phase <= !phase; // first high after the first edge out of reset
	end

	assign sync = phase;

	// the channels count frame positions from this strobe so its period must match frame_len
	assert property (@(posedge clk80) disable iff (reset)
		sync |=> !sync ##(frame_clk80 - 1) sync)
	else
		$error("sync period does not match frame_len at %0t", $time);

endmodule

// File: source/trigger_in_async.sv
`timescale 1ns/100ps

module trigger_in_async
	import trigger_timing_pkg::*;
	import trigger_event_pkg::*;
#(
	parameter int veto_frames = 3
)
(
	input  logic clk80,
	input  logic clk400,
	input  logic reset,
	input  logic sync,
	input  logic trigger_in,
	output chan_trigger_t chan_event
);

	localparam int veto_w = (veto_frames > 0) ? $clog2(veto_frames + 1) : 1;

	//////////////////////////////
	// oversampling and denoise

	logic [denoise_delay-1:0] trg_in;
	logic trg_denoise;
	logic trg_delay;
	logic trg_start;
	logic trg_stop;

	always_ff @(posedge clk400 or posedge reset)
	begin
		if (reset)
			trg_in <= '0;
		else
			trg_in <= {trg_in[denoise_delay-2:0], trigger_in};
	end

	// rise needs both window ends high plus one sample between
	always_ff @(posedge clk400 or posedge reset)
	begin
		if (reset)
			trg_denoise <= 1'b0;
		else if (trg_in[denoise_delay-1] && trg_in[0])
		begin
			if (|trg_in[denoise_delay-2:1])
				trg_denoise <= 1'b1;
		end
		else if (trg_in[denoise_delay-2:0] == '0)
			trg_denoise <= 1'b0; // three low samples in a row
	end

	always_ff @(posedge clk400 or posedge reset)
	begin
		if (reset)
			trg_delay <= 1'b0;
		else
			trg_delay <= trg_denoise;
	end

	assign trg_start = trg_denoise && !trg_delay;
	assign trg_stop = !trg_denoise && trg_delay;

	//////////////////////////////
	// frame clear and stop

	// clk80 falls halfway between two clk400 edges so its fall is seen cleanly
	// and the sync edge follows two clk400 cycles later
	logic clk80_q;
	logic clk80_fall;
	logic [2:0] clear_pipe;
	logic clear;
	logic stop;

	assign clk80_fall = clk80_q && !clk80;

	always_ff @(posedge clk400 or posedge reset)
	begin
		if (reset)
		begin
			clk80_q <= 1'b0;
			clear_pipe <= '0;
			stop <= 1'b0;
		end
		else
		begin
			clk80_q <= clk80;
			clear_pipe <= {clear_pipe[1:0], clk80_fall && sync};
			stop <= clear; // closes the frame one cycle after the clear
		end
	end

	assign clear = clear_pipe[2]; // high in the clk400 cycle that starts at the sync edge

	frame_pos_t poscnt;

	always_ff @(posedge clk400 or posedge reset)
	begin
		if (reset)
			poscnt <= '0;
		else if (clear || poscnt == frame_pos_t'(frame_len - 1))
			poscnt <= '0; // the wrap keeps it in range before the first clear
		else
			poscnt <= poscnt + 1'b1;
	end

	//////////////////////////////
	// trigger store

	logic trg_reg; // held until the frame closes
	logic trg_reg1; // held until the filtered level falls
	logic running;
	frame_pos_t pos_reg;

	assign running = trg_reg || trg_reg1;

	always_ff @(posedge clk400 or posedge reset)
	begin
		if (reset)
		begin
			trg_reg <= 1'b0;
			trg_reg1 <= 1'b0;
		end
		else if (running)
		begin
			if (stop)
				trg_reg <= 1'b0;
			if (trg_stop)
				trg_reg1 <= 1'b0;
		end
		else if (trg_start)
		begin
			trg_reg <= 1'b1;
			trg_reg1 <= 1'b1;
		end
	end

	always_ff @(posedge clk400)
	begin
		if (!running && trg_start)
			pos_reg <= poscnt;
	end

	//////////////////////////////
	// handover to clk80 and veto

	logic trg400_out;
	frame_pos_t trg400_pos;

	always_ff @(posedge clk400 or posedge reset)
	begin
		if (reset)
			trg400_out <= 1'b0;
		else if (stop)
			trg400_out <= trg_reg; // stable across the next sync edge
	end

	always_ff @(posedge clk400)
	begin
		if (stop)
			trg400_pos <= pos_reg;
	end

	logic hit;
	logic veto;
	logic [veto_w-1:0] veto_cnt; // frames left to block
	frame_pos_t hit_pos;

	assign veto = |veto_cnt;

	always_ff @(posedge clk80 or posedge reset)
	begin
		if (reset)
		begin
			hit <= 1'b0;
			veto_cnt <= '0;
		end
		else if (sync)
		begin
			hit <= trg400_out && !veto;
			if (veto)
				veto_cnt <= veto_cnt - 1'b1;
			else if (trg400_out)
				veto_cnt <= veto_w'(veto_frames);
		end
		else
			hit <= 1'b0; // one clk80 cycle per frame
	end

	// position follows the frames even while vetoed
	always_ff @(posedge clk80)
	begin
		if (sync)
			hit_pos <= trg400_pos;
	end

	assign chan_event = '{hit: hit, pos: hit_pos};

	assert property (@(posedge clk400) disable iff (reset)
		trg_reg |-> pos_reg < frame_len)
	else
		$error("stored position %0d outside the frame at %0t", pos_reg, $time);

	assert property (@(posedge clk80) disable iff (reset)
		chan_event.hit |-> $past(sync))
	else
		$error("hit not aligned to sync at %0t", $time);

endmodule

// File: source/trigger_select.sv
`timescale 1ns/100ps

module trigger_select
	import trigger_timing_pkg::*;
	import trigger_event_pkg::*;
#(
	parameter int n_channels = 2
)
(
	input  logic clk80,
	input  logic reset,
	input  logic sync,
	input  logic [n_channels-1:0] channel_mask,
	input  chan_trigger_t events [n_channels],
	output trigger_word_t trigger
);

	//////////////////////////////
	// frame alignment

	logic sync_d; // high in the cycle where channel hits are valid

	always_ff @(posedge clk80 or posedge reset)
	begin
		if (reset)
			sync_d <= 1'b0;
		else
			sync_d <= sync;
	end

	//////////////////////////////
	// mask and priority

	logic [n_channels-1:0] masked;
	logic sel_hit;
	source_t sel_idx;
	frame_pos_t sel_pos;
	logic take;

	always_comb
	begin
		for (int i = 0; i < n_channels; i++)
			masked[i] = events[i].hit && channel_mask[i];
	end

	// walk down so the lowest index is the last to win
	always_comb
	begin
		sel_hit = 1'b0;
		sel_idx = '0;
		sel_pos = '0;
		for (int i = n_channels - 1; i >= 0; i--)
		begin
			if (masked[i])
			begin
				sel_hit = 1'b1;
				sel_idx = source_t'(i);
				sel_pos = events[i].pos;
			end
		end
	end

	assign take = sel_hit && sync_d; // losers in the same frame are dropped

	//////////////////////////////
	// output word and event number

	logic valid_r;
	event_num_t count;
	source_t source_r;
	frame_pos_t pos_r;
	event_num_t number_r;

	always_ff @(posedge clk80 or posedge reset)
	begin
		if (reset)
		begin
			valid_r <= 1'b0;
			count <= '0;
		end
		else
		begin
			valid_r <= take;
			if (take)
				count <= count + 1'b1;
		end
	end

	always_ff @(posedge clk80)
	begin
		if (take)
		begin
			source_r <= sel_idx;
			pos_r <= sel_pos;
			number_r <= count; // number before the increment
		end
	end

	assign trigger = '{
		valid: valid_r,
		source: source_r,
		pos: pos_r,
		number: number_r
	};

	// channels hit at most once per frame so the strobe can not repeat
	assert property (@(posedge clk80) disable iff (reset)
		trigger.valid |=> !trigger.valid)
	else
		$error("trigger.valid high on consecutive clk80 cycles at %0t", $time);

endmodule

// File: source/trigger_frontend.sv
`timescale 1ns/100ps

module trigger_frontend
	import trigger_event_pkg::*;
#(
	parameter int n_channels = 2,
	parameter int veto_frames = 3
)
(
	input  logic clk80,
	input  logic clk400,
	input  logic reset,
	input  logic [n_channels-1:0] trigger_in,
	input  logic [n_channels-1:0] channel_mask,
	output logic sync,
	output trigger_word_t trigger
);

	chan_trigger_t events [n_channels]; // one per input channel

	//////////////////////////////
	// frame strobe

	frame_sync_gen frame_sync_gen_inst
	(
		.clk80(clk80),
		.reset(reset),
		.sync(sync)
	);

	//////////////////////////////
	// input channels

	for (genvar i = 0; i < n_channels; i++)
	begin : channel_gen
		trigger_in_async
		#(
			.veto_frames(veto_frames)
		)
		trigger_in_async_inst
		(
			.clk80(clk80),
			.clk400(clk400),
			.reset(reset),
			.sync(sync),
			.trigger_in(trigger_in[i]),
			.chan_event(events[i])
		);
	end

	//////////////////////////////
	// selector

	trigger_select
	#(
		.n_channels(n_channels)
	)
	trigger_select_inst
	(
		.clk80(clk80),
		.reset(reset),
		.sync(sync),
		.channel_mask(channel_mask),
		.events(events),
		.trigger(trigger)
	);

endmodule

// File: bench/trigger_frontend_tb.sv
`timescale 1ns/100ps

module trigger_frontend_tb
	import trigger_timing_pkg::*;
	import trigger_event_pkg::*;
();

	localparam int n_channels = 2;
	localparam int veto_frames = 3;
	localparam int word_timeout = 40; // clk80 cycles
	localparam int clk400_period = 8;
	localparam int clk80_period = clk_ratio * clk400_period;

	logic clk400 = 1'b0;
	logic clk80 = 1'b0;
	logic reset;
	logic [n_channels-1:0] trigger_in;
	logic [n_channels-1:0] channel_mask;
	logic sync;
	trigger_word_t trigger;

	trigger_word_t words [$];
	time word_times [$];
	trigger_word_t seen;
	time seen_time;
	int frame_phase = 0; // clk400 edges since the last clk80 edge that carried sync
	logic sync_q = 1'b0;
	int exp_number = 0;
	int test_checks = 0;
	int test_errors = 0;
	int total_checks = 0;
	int total_errors = 0;
	int tests_run = 0;

	//////////////////////////////
	// clocks and DUT

	initial
	begin
		forever #(clk400_period / 2) clk400 = ~clk400;
	end

	// every fifth clk400 change keeps clk80 rising with clk400
	initial
	begin
		forever
		begin
			repeat (clk_ratio) @(clk400);
			clk80 = ~clk80;
		end
	end

	trigger_frontend #(.n_channels(n_channels), .veto_frames(veto_frames)) trigger_frontend_inst
	(
		.clk80(clk80),
		.clk400(clk400),
		.reset(reset),
		.trigger_in(trigger_in),
		.channel_mask(channel_mask),
		.sync(sync),
		.trigger(trigger)
	);

	//////////////////////////////
	// frame model and word monitor

	// sync read here still holds the value from before this edge
	always @(posedge clk400)
	begin
		sync_q <= sync;
		if (sync_q && !sync)
			frame_phase <= 1; // one edge after the sync edge
		else
			frame_phase <= (frame_phase + 1) % frame_len;
	end

	always @(negedge clk80)
	begin
		if (trigger.valid === 1'b1)
		begin
			words.push_back(trigger);
			word_times.push_back($time);
		end
	end

	//////////////////////////////
	// helpers

	// the filter fires denoise_delay edges after the first sample, which lands one edge late
	function automatic frame_pos_t predict_pos(input int phase_before);
		return frame_pos_t'((phase_before + 1 + denoise_delay) % frame_len);
	endfunction

	task automatic compare(input string name, input logic [31:0] expected, input logic [31:0] actual);
		test_checks++;
		assert (expected === actual)
		else
		begin
			$display("FAIL %0t %s expected %0d seen %0d", $time, name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic pulse(input logic [n_channels-1:0] lanes, input int len, output frame_pos_t pos);
		@(posedge clk400);
		trigger_in <= lanes;
		pos = predict_pos(frame_phase); // frame_phase still holds the previous edge
		repeat (len) @(posedge clk400);
		trigger_in <= '0;
	endtask

	task automatic set_mask(input logic [n_channels-1:0] mask);
		@(posedge clk400);
		channel_mask <= mask;
	endtask

	task automatic let_veto_expire();
		repeat ((veto_frames + 1) * frame_len) @(posedge clk400);
	endtask

	task automatic await_word(output bit got);
		int waited;
		waited = 0;
		got = 1'b0;
		while (words.size() == 0 && waited < word_timeout)
		begin
			@(posedge clk80);
			waited++;
		end
		if (words.size() > 0)
		begin
			got = 1'b1;
			seen = words.pop_front();
			seen_time = word_times.pop_front();
		end
	endtask

	task automatic check_word(input bit got, input int source, input frame_pos_t pos);
		test_checks++;
		assert (got)
		else
		begin
			$display("no trigger word arrived within %0d clk80 cycles at %0t", word_timeout, $time);
			test_errors++;
		end
		if (got)
		begin
			compare("trigger.source", source, seen.source);
			compare("trigger.pos", pos, seen.pos);
			compare("trigger.number", exp_number, seen.number);
			exp_number++;
		end
	endtask

	task automatic expect_silence(input string what);
		bit got;
		await_word(got);
		test_checks++;
		assert (!got)
		else
		begin
			$display("unexpected trigger word after %s at %0t", what, $time);
			test_errors++;
		end
		if (got)
			exp_number++; // the DUT counted it
	endtask

	task automatic end_test(input string name);
		$display("%-18s checks %0d errors %0d", name, test_checks, test_errors);
		tests_run++;
		total_checks += test_checks;
		total_errors += test_errors;
		test_checks = 0;
		test_errors = 0;
	endtask

	//////////////////////////////
	// tests

	task automatic reset_state();
		logic prev;
		@(posedge clk400);
		@(negedge clk400);
		compare("sync", 0, sync);
		compare("trigger.valid", 0, trigger.valid);
		@(posedge clk400);
		reset <= 1'b0;
		@(negedge clk400);
		compare("sync", 0, sync);
		compare("trigger.valid", 0, trigger.valid);
		@(negedge clk80);
		prev = sync;
		repeat (8)
		begin
			@(negedge clk80);
			compare("sync", !prev, sync);
			compare("trigger.valid", 0, trigger.valid);
			prev = sync;
		end
		end_test("reset state");
	endtask

	task automatic positions_in_frame();
		frame_pos_t pos;
		int offset;
		bit got;
		for (int i = 0; i < 8; i++)
		begin
			let_veto_expire();
			offset = $urandom % frame_len;
			repeat (offset) @(posedge clk400);
			pulse(2'b01, 6, pos);
			await_word(got);
			check_word(got, 0, pos);
		end
		end_test("position");
	endtask

	task automatic glitch_rejection();
		frame_pos_t pos;
		bit got;
		for (int len = 1; len < denoise_delay; len++)
		begin
			let_veto_expire();
			pulse(2'b01, len, pos);
			expect_silence($sformatf("a %0d cycle pulse", len));
		end
		let_veto_expire();
		pulse(2'b01, denoise_delay, pos);
		await_word(got);
		check_word(got, 0, pos);
		end_test("glitch rejection");
	endtask

	task automatic veto_window();
		frame_pos_t pos_first;
		frame_pos_t pos_blocked;
		frame_pos_t pos_late;
		time first_time;
		bit got;
		let_veto_expire();
		pulse(2'b01, 6, pos_first);
		repeat (frame_len - 7) @(posedge clk400);
		pulse(2'b01, 6, pos_blocked); // one frame later, inside the veto
		repeat (veto_frames * frame_len - 7) @(posedge clk400);
		pulse(2'b01, 6, pos_late); // first frame after the veto
		await_word(got);
		check_word(got, 0, pos_first);
		first_time = seen_time;
		await_word(got);
		check_word(got, 0, pos_late);
		if (got)
			compare("clk80 cycles between words",
				(veto_frames + 1) * frame_len / clk_ratio,
				(seen_time - first_time) / clk80_period);
		expect_silence("the veto sequence");
		end_test("veto");
	endtask

	task automatic mask_and_priority();
		frame_pos_t pos;
		bit got;
		let_veto_expire();
		pulse(2'b11, 6, pos);
		await_word(got);
		check_word(got, 0, pos);
		expect_silence("a pair in one frame");
		set_mask(2'b10);
		let_veto_expire();
		pulse(2'b11, 6, pos);
		await_word(got);
		check_word(got, 1, pos);
		set_mask(2'b00);
		let_veto_expire();
		pulse(2'b11, 6, pos);
		expect_silence("a pair with both channels masked");
		set_mask(2'b11);
		end_test("mask and priority");
	endtask

	initial
	begin
		void'($urandom(91));
		reset = 1'b1;
		trigger_in = '0;
		channel_mask = '1;
		reset_state();
		positions_in_frame();
		glitch_rejection();
		veto_window();
		mask_and_priority();
		$display("tests %0d, checks %0d, errors %0d", tests_run, total_checks, total_errors);
		if (total_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: project.f
source/trigger_timing_pkg.sv
source/trigger_event_pkg.sv
source/frame_sync_gen.sv
source/trigger_in_async.sv
source/trigger_select.sv
source/trigger_frontend.sv
bench/trigger_frontend_tb.sv
